//--- logic/sata_defines.svh
// SATA transmit constants
`ifndef SATA_DEFINES_SVH
`define SATA_DEFINES_SVH

// Widths
`define SATA_DWORD_W      32
`define SATA_LBA_W        48
`define SATA_COUNT_W      16
`define SATA_LEN_W        8

// Link FIFO depth, also the credits held by the arbiter
`define SATA_TX_CREDITS   4

// Primitives
`define SATA_PRIM_SYNC    32'hB5B5957C
`define SATA_PRIM_SOF     32'h3737B57C
`define SATA_PRIM_EOF     32'hD5D5B57C
`define SATA_PRIM_HOLDA   32'h9595AA7C

// FIS type codes
`define SATA_FIS_REG_H2D  8'h27
`define SATA_FIS_DATA     8'h46

`define SATA_CRC_INIT     32'h52325032
`define SATA_CRC_POLY     32'h04C11DB7

`endif

//--- logic/sata_pkg.sv
// SATA transmit types
`default_nettype none

`include "sata_defines.svh"

package sata_pkg;

  typedef logic [`SATA_DWORD_W-1:0] dword_t;
  typedef logic [`SATA_LBA_W-1:0]   lba_t;
  typedef logic [`SATA_COUNT_W-1:0] sector_count_t;
  typedef logic [15:0]              features_t;
  typedef logic [7:0]               command_t;
  typedef logic [`SATA_LEN_W-1:0]   fis_len_t;

  // Counts 0 up to the full credit depth
  typedef logic [$clog2(`SATA_TX_CREDITS + 1)-1:0] credit_t;

  typedef enum logic [1:0] {DATA_IDLE, DATA_HEADER, DATA_PAYLOAD} data_state_t;

  typedef enum logic [2:0] {LINK_SYNC, LINK_SOF, LINK_DATA, LINK_CRC, LINK_EOF} link_state_t;

endpackage

`default_nettype wire

//--- logic/sata_reg_fis_builder.sv
// Register FIS builder
`timescale 1ns/10ps
`default_nettype none

`include "sata_defines.svh"

module sata_reg_fis_builder (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         send_command_stb,
  input  wire sata_pkg::command_t     hard_drive_command,
  input  wire sata_pkg::lba_t         sector_address,
  input  wire sata_pkg::sector_count_t sector_count,
  input  wire sata_pkg::features_t    user_features,
  output logic                        busy,
  output logic                        req,
  output sata_pkg::dword_t            dword,
  output logic                        last,
  input  wire                         take
);

  import sata_pkg::*;

  command_t       cmd_q;
  lba_t           lba_q;
  sector_count_t  count_q;
  features_t      feat_q;
  logic [2:0]     idx_q;
  logic           busy_q;
  logic           accept;

  assign accept = send_command_stb && !busy_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (busy_q && take) begin
      idx_q <= idx_q + 3'd1;
      if (last) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Command fields held for the whole frame
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q   <= hard_drive_command;
      lba_q   <= sector_address;
      count_q <= sector_count;
      feat_q  <= user_features;
    end
  end

  always_comb begin
    case (idx_q)
      // C bit is bit 7 of the second byte
      3'd0:    dword = {feat_q[7:0], cmd_q, 8'h80, `SATA_FIS_REG_H2D};
      3'd1:    dword = {8'h40, lba_q[23:0]};
      3'd2:    dword = {feat_q[15:8], lba_q[47:24]};
      3'd3:    dword = {16'h0000, count_q};
      default: dword = '0;
    endcase
  end

  assign last = (idx_q == 3'd4);
  assign req  = busy_q;
  assign busy = busy_q;

endmodule

`default_nettype wire

//--- logic/sata_data_fis_builder.sv
// Data FIS builder
`timescale 1ns/10ps
`default_nettype none

`include "sata_defines.svh"

module sata_data_fis_builder (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     send_data_stb,
  input  wire sata_pkg::fis_len_t data_dword_count,
  input  wire sata_pkg::dword_t   user_din,
  input  wire                     user_din_stb,
  output logic                    user_din_ready,
  output logic                    busy,
  output logic                    req,
  output sata_pkg::dword_t        dword,
  output logic                    last,
  input  wire                     take
);

  import sata_pkg::*;

  data_state_t  state_q;
  fis_len_t     remain_q;
  logic         held_q;
  dword_t       held_dword_q;
  logic         accept;
  logic         din_load;

  assign accept   = send_data_stb && (state_q == DATA_IDLE);
  assign din_load = user_din_stb && user_din_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= DATA_IDLE;
      remain_q <= '0;
      held_q   <= 1'b0;
    end else begin
      case (state_q)
        DATA_IDLE: begin
          if (accept) begin
            state_q  <= DATA_HEADER;
            remain_q <= data_dword_count;
          end
        end
        DATA_HEADER: begin
          if (take) begin
            state_q <= DATA_PAYLOAD;
          end
        end
        DATA_PAYLOAD: begin
          // One user dword in flight at a time
          if (din_load) begin
            held_q   <= 1'b1;
            remain_q <= remain_q - 1'b1;
          end else if (take) begin
            held_q <= 1'b0;
            if (remain_q == '0) begin
              state_q <= DATA_IDLE;
            end
          end
        end
        default: state_q <= DATA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (din_load) begin
      held_dword_q <= user_din;
    end
  end

  assign user_din_ready = (state_q == DATA_PAYLOAD) && !held_q && (remain_q != '0);
  assign busy           = (state_q != DATA_IDLE);
  assign req            = (state_q == DATA_HEADER) || held_q;
  assign dword          = (state_q == DATA_HEADER) ? {24'h000000, `SATA_FIS_DATA} : held_dword_q;
  // Count already dropped when the final dword was loaded
  assign last           = held_q && (remain_q == '0);

endmodule

`default_nettype wire

//--- logic/sata_fis_arbiter.sv
// FIS transmit arbiter
`timescale 1ns/10ps
`default_nettype none

`include "sata_defines.svh"

module sata_fis_arbiter (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   reg_req,
  input  wire sata_pkg::dword_t reg_dword,
  input  wire                   reg_last,
  output logic                  reg_take,
  input  wire                   data_req,
  input  wire sata_pkg::dword_t data_dword,
  input  wire                   data_last,
  output logic                  data_take,
  output logic                  fifo_push,
  output sata_pkg::dword_t      fifo_dword,
  output logic                  fifo_last,
  input  wire                   credit_return
);

  import sata_pkg::*;

  credit_t  credits_q;
  logic     active_q;
  logic     grant_data_q;
  logic     served_data_q;
  logic     sel_data;
  logic     sel_req;

  // Grant sticks for a whole frame, ties go to the builder not served last
  always_comb begin
    if (active_q) begin
      sel_data = grant_data_q;
    end else if (reg_req && data_req) begin
      sel_data = !served_data_q;
    end else begin
      sel_data = data_req;
    end
  end

  assign sel_req    = sel_data ? data_req : reg_req;
  assign fifo_push  = sel_req && (credits_q != '0);
  assign fifo_dword = sel_data ? data_dword : reg_dword;
  assign fifo_last  = sel_data ? data_last : reg_last;
  assign reg_take   = fifo_push && !sel_data;
  assign data_take  = fifo_push && sel_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits_q     <= credit_t'(`SATA_TX_CREDITS);
      active_q      <= 1'b0;
      grant_data_q  <= 1'b0;
      // First tie goes to the command side
      served_data_q <= 1'b1;
    end else begin
      case ({fifo_push, credit_return})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
      if (fifo_push) begin
        if (fifo_last) begin
          active_q      <= 1'b0;
          served_data_q <= sel_data;
        end else begin
          active_q     <= 1'b1;
          grant_data_q <= sel_data;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/sata_link_tx.sv
// Link layer transmitter
`timescale 1ns/10ps
`default_nettype none

`include "sata_defines.svh"

module sata_link_tx (
  input  wire                   clk,
  input  wire                   arst_n,
  input  wire                   fifo_push,
  input  wire sata_pkg::dword_t fifo_dword,
  input  wire                   fifo_last,
  output logic                  credit_return,
  input  wire                   hold,
  output sata_pkg::dword_t      tx_dout,
  output logic                  tx_is_k
);

  import sata_pkg::*;

  localparam int PTR_W = $clog2(`SATA_TX_CREDITS);

  dword_t             fifo_mem [`SATA_TX_CREDITS];
  logic               last_mem [`SATA_TX_CREDITS];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  credit_t            fill_q;
  link_state_t        state_q;
  link_state_t        state_d;
  dword_t             crc_q;
  dword_t             head_dword;
  logic               head_last;
  logic               fifo_empty;
  logic               pop;

  // MSB-first CRC32 over one dword
  function automatic dword_t crc_next(input dword_t crc, input dword_t data);
    dword_t c;
    logic   fb;
    c = crc;
    for (int i = `SATA_DWORD_W - 1; i >= 0; i--) begin
      fb = c[`SATA_DWORD_W-1] ^ data[i];
      c  = c << 1;
      if (fb) begin
        c = c ^ `SATA_CRC_POLY;
      end
    end
    return c;
  endfunction

  assign head_dword    = fifo_mem[rd_ptr_q];
  assign head_last     = last_mem[rd_ptr_q];
  assign fifo_empty    = (fill_q == '0);
  assign pop           = (state_q == LINK_DATA) && !hold && !fifo_empty;
  assign credit_return = pop;

  always_ff @(posedge clk) begin
    if (fifo_push) begin
      fifo_mem[wr_ptr_q] <= fifo_dword;
      last_mem[wr_ptr_q] <= fifo_last;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      state_q  <= LINK_SYNC;
    end else begin
      state_q <= state_d;
      if (fifo_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({fifo_push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // Seeded while SOF goes out
  always_ff @(posedge clk) begin
    if (state_q == LINK_SOF) begin
      crc_q <= `SATA_CRC_INIT;
    end else if (pop) begin
      crc_q <= crc_next(crc_q, head_dword);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      LINK_SYNC: if (!fifo_empty) state_d = LINK_SOF;
      LINK_SOF:  state_d = LINK_DATA;
      LINK_DATA: if (pop && head_last) state_d = LINK_CRC;
      LINK_CRC:  state_d = LINK_EOF;
      LINK_EOF:  state_d = fifo_empty ? LINK_SYNC : LINK_SOF;
      default:   state_d = LINK_SYNC;
    endcase
  end

  always_comb begin
    tx_dout = `SATA_PRIM_SYNC;
    tx_is_k = 1'b1;
    case (state_q)
      LINK_SOF: tx_dout = `SATA_PRIM_SOF;
      LINK_DATA: begin
        // HOLDA under device hold, and also while the FIFO runs dry
        if (pop) begin
          tx_dout = head_dword;
          tx_is_k = 1'b0;
        end else begin
          tx_dout = `SATA_PRIM_HOLDA;
        end
      end
      LINK_CRC: begin
        tx_dout = crc_q;
        tx_is_k = 1'b0;
      end
      LINK_EOF: tx_dout = `SATA_PRIM_EOF;
      default:  tx_dout = `SATA_PRIM_SYNC;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/sata_stack.sv
// SATA host transmit stack
`timescale 1ns/10ps
`default_nettype none

module sata_stack (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          send_command_stb,
  input  wire sata_pkg::command_t      hard_drive_command,
  input  wire sata_pkg::lba_t          sector_address,
  input  wire sata_pkg::sector_count_t sector_count,
  input  wire sata_pkg::features_t     user_features,
  input  wire                          send_data_stb,
  input  wire sata_pkg::fis_len_t      data_dword_count,
  input  wire sata_pkg::dword_t        user_din,
  input  wire                          user_din_stb,
  output logic                         user_din_ready,
  output logic                         sata_busy,
  input  wire                          hold,
  output sata_pkg::dword_t             tx_dout,
  output logic                         tx_is_k
);

  import sata_pkg::*;

  logic   reg_busy;
  logic   reg_req;
  dword_t reg_dword;
  logic   reg_last;
  logic   reg_take;
  logic   data_busy;
  logic   data_req;
  dword_t data_dword;
  logic   data_last;
  logic   data_take;
  logic   fifo_push;
  dword_t fifo_dword;
  logic   fifo_last;
  logic   credit_return;

  assign sata_busy = reg_busy | data_busy;

  sata_reg_fis_builder reg_builder (
    .clk                (clk),
    .arst_n             (arst_n),
    .send_command_stb   (send_command_stb),
    .hard_drive_command (hard_drive_command),
    .sector_address     (sector_address),
    .sector_count       (sector_count),
    .user_features      (user_features),
    .busy               (reg_busy),
    .req                (reg_req),
    .dword              (reg_dword),
    .last               (reg_last),
    .take               (reg_take)
  );

  sata_data_fis_builder data_builder (
    .clk              (clk),
    .arst_n           (arst_n),
    .send_data_stb    (send_data_stb),
    .data_dword_count (data_dword_count),
    .user_din         (user_din),
    .user_din_stb     (user_din_stb),
    .user_din_ready   (user_din_ready),
    .busy             (data_busy),
    .req              (data_req),
    .dword            (data_dword),
    .last             (data_last),
    .take             (data_take)
  );

  // Both builders share the one link port
  sata_fis_arbiter arbiter (
    .clk           (clk),
    .arst_n        (arst_n),
    .reg_req       (reg_req),
    .reg_dword     (reg_dword),
    .reg_last      (reg_last),
    .reg_take      (reg_take),
    .data_req      (data_req),
    .data_dword    (data_dword),
    .data_last     (data_last),
    .data_take     (data_take),
    .fifo_push     (fifo_push),
    .fifo_dword    (fifo_dword),
    .fifo_last     (fifo_last),
    .credit_return (credit_return)
  );

  sata_link_tx link_tx (
    .clk           (clk),
    .arst_n        (arst_n),
    .fifo_push     (fifo_push),
    .fifo_dword    (fifo_dword),
    .fifo_last     (fifo_last),
    .credit_return (credit_return),
    .hold          (hold),
    .tx_dout       (tx_dout),
    .tx_is_k       (tx_is_k)
  );

endmodule

`default_nettype wire

//--- bench/sata_stack_tb.sv
// SATA transmit stack testbench
`timescale 1ns/10ps
`default_nettype none

`include "sata_defines.svh"

module sata_stack_tb;

  import sata_pkg::*;

  localparam int NUM_TRANSFERS = 40;
  localparam int WAIT_LIMIT    = 1000;

  logic          clk;
  logic          arst_n;
  logic          send_command_stb;
  command_t      hard_drive_command;
  lba_t          sector_address;
  sector_count_t sector_count;
  features_t     user_features;
  logic          send_data_stb;
  fis_len_t      data_dword_count;
  dword_t        user_din;
  logic          user_din_stb;
  logic          user_din_ready;
  logic          sata_busy;
  logic          hold = 1'b0;
  dword_t        tx_dout;
  logic          tx_is_k;

  integer        seed;
  // Expected frames, flattened, with one length entry per frame
  dword_t        exp_words[$];
  int            exp_lens[$];
  dword_t        got[$];
  bit            in_frame = 1'b0;
  int            held_words;
  bit            last_held;
  int            stall_cycles = 0;
  int            n;
  int            cycles;

  sata_stack uut (
    .clk                (clk),
    .arst_n             (arst_n),
    .send_command_stb   (send_command_stb),
    .hard_drive_command (hard_drive_command),
    .sector_address     (sector_address),
    .sector_count       (sector_count),
    .user_features      (user_features),
    .send_data_stb      (send_data_stb),
    .data_dword_count   (data_dword_count),
    .user_din           (user_din),
    .user_din_stb       (user_din_stb),
    .user_din_ready     (user_din_ready),
    .sata_busy          (sata_busy),
    .hold               (hold),
    .tx_dout            (tx_dout),
    .tx_is_k            (tx_is_k)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped on the first failed check");
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped on a timeout");
  endtask

  // Bit-serial CRC32, data MSB first
  function automatic dword_t crc_update(input dword_t crc, input dword_t d);
    dword_t r;
    int     b;
    r = crc;
    for (b = `SATA_DWORD_W - 1; b >= 0; b--) begin
      r = {r[30:0], 1'b0} ^ (`SATA_CRC_POLY & {32{r[31] ^ d[b]}});
    end
    return r;
  endfunction

  function automatic bit is_primitive(input dword_t d);
    return (d == `SATA_PRIM_SYNC) || (d == `SATA_PRIM_SOF) ||
           (d == `SATA_PRIM_EOF) || (d == `SATA_PRIM_HOLDA);
  endfunction

  task automatic check_frame();
    int     len;
    int     i;
    dword_t w;
    dword_t crc;
    assert (exp_lens.size() != 0) else report_mismatch("frame seen with nothing pending");
    len = exp_lens.pop_front();
    assert (got.size() == len + 1)
      else report_mismatch($sformatf("frame has %0d dwords, expected %0d", got.size() - 1, len));
    // Only the CRC dword may go out while hold is high
    assert (held_words == 0 || (held_words == 1 && last_held))
      else report_mismatch("payload dword sent while hold was high");
    crc = `SATA_CRC_INIT;
    for (i = 0; i < len; i++) begin
      w = exp_words.pop_front();
      assert (got[i] == w)
        else report_mismatch($sformatf("dword %0d is %h, expected %h", i, got[i], w));
      crc = crc_update(crc, w);
    end
    assert (got[len] == crc)
      else report_mismatch($sformatf("CRC is %h, expected %h", got[len], crc));
  endtask

  // Frame monitor on the transmit lane
  always @(posedge clk) begin
    if (arst_n) begin
      if (tx_is_k) begin
        assert (is_primitive(tx_dout))
          else report_mismatch($sformatf("K flag on non-primitive %h", tx_dout));
      end
      if (!in_frame) begin
        if (tx_is_k && tx_dout == `SATA_PRIM_SOF) begin
          in_frame   = 1'b1;
          held_words = 0;
          last_held  = 1'b0;
          got.delete();
        end else begin
          assert (tx_is_k && tx_dout == `SATA_PRIM_SYNC)
            else report_mismatch($sformatf("%h between frames, expected SYNC", tx_dout));
        end
      end else if (!tx_is_k) begin
        got.push_back(tx_dout);
        last_held = hold;
        if (hold) held_words++;
      end else if (tx_dout == `SATA_PRIM_EOF) begin
        check_frame();
        in_frame     = 1'b0;
        stall_cycles = 0;
      end else begin
        assert (tx_dout == `SATA_PRIM_HOLDA)
          else report_mismatch($sformatf("primitive %h inside a frame", tx_dout));
      end
      if (exp_lens.size() != 0) begin
        stall_cycles++;
        if (stall_cycles > WAIT_LIMIT) abort_on_timeout("a frame to reach tx_dout");
      end
    end
  end

  // Device hold, random each cycle
  always @(posedge clk) begin
    if (!arst_n) begin
      hold <= 1'b0;
    end else begin
      hold <= (($random(seed) & 3) == 0);
    end
  end

  task automatic wait_until_idle();
    int count;
    count = 0;
    do begin
      @(posedge clk);
      count++;
      if (count > WAIT_LIMIT) abort_on_timeout("sata_busy to go low");
    end while (sata_busy);
  endtask

  task automatic send_command();
    command_t      cmd;
    lba_t          lba;
    sector_count_t cnt;
    features_t     feat;
    cmd  = 8'($random(seed));
    lba  = {16'($random(seed)), 32'($random(seed))};
    cnt  = 16'($random(seed));
    feat = 16'($random(seed));
    send_command_stb   <= 1'b1;
    hard_drive_command <= cmd;
    sector_address     <= lba;
    sector_count       <= cnt;
    user_features      <= feat;
    exp_words.push_back({feat[7:0], cmd, 8'h80, `SATA_FIS_REG_H2D});
    exp_words.push_back({8'h40, lba[23:0]});
    exp_words.push_back({feat[15:8], lba[47:24]});
    exp_words.push_back({16'h0000, cnt});
    exp_words.push_back(32'h0000_0000);
    exp_lens.push_back(5);
    @(posedge clk);
    send_command_stb <= 1'b0;
  endtask

  task automatic send_data();
    fis_len_t len;
    dword_t   words[$];
    dword_t   w;
    int       i;
    int       count;
    len = fis_len_t'(1 + ($unsigned($random(seed)) % 12));
    exp_words.push_back({24'h000000, `SATA_FIS_DATA});
    for (i = 0; i < len; i++) begin
      w = $random(seed);
      words.push_back(w);
      exp_words.push_back(w);
    end
    exp_lens.push_back(len + 1);
    send_data_stb    <= 1'b1;
    data_dword_count <= len;
    @(posedge clk);
    send_data_stb <= 1'b0;
    for (i = 0; i < len; i++) begin
      count = 0;
      do begin
        @(posedge clk);
        count++;
        if (count > WAIT_LIMIT) abort_on_timeout("user_din_ready");
      end while (!user_din_ready);
      user_din_stb <= 1'b1;
      user_din     <= words[i];
      @(posedge clk);
      user_din_stb <= 1'b0;
    end
  endtask

  initial begin
    seed               = 90;
    arst_n             = 1'b0;
    send_command_stb   = 1'b0;
    hard_drive_command = '0;
    sector_address     = '0;
    sector_count       = '0;
    user_features      = '0;
    send_data_stb      = 1'b0;
    data_dword_count   = '0;
    user_din           = '0;
    user_din_stb       = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (3) begin
      @(posedge clk);
      assert (!sata_busy && !user_din_ready) else report_mismatch("busy or ready after reset");
      assert (tx_is_k && tx_dout == `SATA_PRIM_SYNC) else report_mismatch("no SYNC after reset");
    end
    for (n = 0; n < NUM_TRANSFERS; n++) begin
      wait_until_idle();
      repeat ($unsigned($random(seed)) % 3) @(posedge clk);
      if ($random(seed) & 1) begin
        send_command();
      end else begin
        send_data();
      end
    end
    wait_until_idle();
    cycles = 0;
    while (exp_lens.size() != 0 || in_frame) begin
      @(posedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_on_timeout("the last frames to drain");
    end
    repeat (5) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/sata_pkg.sv
logic/sata_reg_fis_builder.sv
logic/sata_data_fis_builder.sv
logic/sata_fis_arbiter.sv
logic/sata_link_tx.sv
logic/sata_stack.sv
bench/sata_stack_tb.sv
